// File: Bender.yml
package:
  name: xdrop_aligner

sources:
  - common/align_cfg_pkg.sv
  - common/nt_pkg.sv
  - common/pe_link_if.sv
  - verilog/align_fsm.sv
  - verilog/stream_counter.sv
  - pe_array/pe.sv
  - pe_array/pe_array.sv
  - verilog/max_tracker.sv
  - verilog/xdrop_aligner.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_xdrop_aligner.sv

// File: bench/align_model.svh
`ifndef ALIGN_MODEL_SVH
`define ALIGN_MODEL_SVH

localparam int MODEL_ROWS = 17;
localparam int MODEL_COLS = 64;
// far below any reachable score
localparam int MODEL_NEG = -1000000;

int h_mat [MODEL_ROWS][MODEL_COLS];
int i_mat [MODEL_ROWS][MODEL_COLS];
int d_mat [MODEL_ROWS][MODEL_COLS];
int exp_score;
int exp_ref_idx;
int exp_query_idx;
bit exp_xdropped;

// 0..3 for A C G T, 4 for anything else
function automatic int base_code(logic [7:0] ch, logic comp);
    int code;
    case (ch)
        "A", "a": code = 0;
        "C", "c": code = 1;
        "G", "g": code = 2;
        "T", "t": code = 3;
        default: code = 4;
    endcase
    if (comp && code < 4) begin
        code = 3 - code;
    end
    return code;
endfunction

function automatic int pair_score(int qb, int rb);
    if (qb == 4 || rb == 4) begin
        return int'(n_score);
    end
    return (qb == rb) ? int'(match) : int'(mismatch);
endfunction

function automatic int larger_of(int a, int b);
    return (a > b) ? a : b;
endfunction

// full affine DP, then the anti-diagonal scan with x-drop
task automatic compute_model();
    int qlen;
    int rlen;
    int go;
    int ge;
    int i;
    int j;
    int d;
    int lo;
    int hi;
    int mi;
    int m;
    int diag;
    qlen = int'(query_len);
    rlen = int'(ref_len);
    go = int'(gap_open);
    ge = int'(gap_extend);
    for (j = 0; j <= rlen; j++) begin
        h_mat[0][j] = (j == 0) ? 0 : go + (j - 1) * ge;
        i_mat[0][j] = MODEL_NEG;
        d_mat[0][j] = MODEL_NEG;
    end
    for (i = 1; i <= qlen; i++) begin
        h_mat[i][0] = go + (i - 1) * ge;
        i_mat[i][0] = MODEL_NEG;
        d_mat[i][0] = MODEL_NEG;
        for (j = 1; j <= rlen; j++) begin
            i_mat[i][j] = larger_of(h_mat[i][j-1] + go, i_mat[i][j-1] + ge);
            d_mat[i][j] = larger_of(h_mat[i-1][j] + go, d_mat[i-1][j] + ge);
            diag = h_mat[i-1][j-1] + pair_score(base_code(query_mem[i-1], complement_query),
                                                base_code(ref_mem[j-1], complement_ref));
            h_mat[i][j] = larger_of(diag, larger_of(i_mat[i][j], d_mat[i][j]));
        end
    end
    exp_score = 0;
    exp_ref_idx = 0;
    exp_query_idx = 0;
    exp_xdropped = 1'b0;
    d = 2;
    while (d <= rlen + qlen && !exp_xdropped) begin
        lo = (d - rlen > 1) ? d - rlen : 1;
        hi = (d - 1 < qlen) ? d - 1 : qlen;
        mi = lo;
        // strict compare keeps the smallest row on a tie
        for (i = lo + 1; i <= hi; i++) begin
            if (h_mat[i][d-i] > h_mat[mi][d-mi]) begin
                mi = i;
            end
        end
        m = h_mat[mi][d-mi];
        if (m >= exp_score) begin
            exp_score = m;
            exp_ref_idx = d - mi;
            exp_query_idx = mi;
        end else if (m < exp_score - int'(xdrop)) begin
            exp_xdropped = 1'b1;
        end
        d++;
    end
endtask

`endif

// File: bench/tb_xdrop_aligner.sv
`timescale 1ns/100ps

module tb_xdrop_aligner;
    import align_cfg_pkg::*;

    localparam int MEM_DEPTH = 256;
    localparam int IDLE_TIMEOUT = 50;
    localparam int START_TIMEOUT = 10;
    localparam int RUN_TIMEOUT = 500;

    logic clk;
    logic rst;
    logic start;
    logic complement_ref;
    logic complement_query;
    score_t match;
    score_t mismatch;
    score_t n_score;
    score_t gap_open;
    score_t gap_extend;
    score_t xdrop;
    idx_t ref_len;
    idx_t query_len;
    logic [7:0] ref_data;
    logic [7:0] query_data;
    idx_t ref_addr;
    idx_t query_addr;
    logic busy;
    logic done;
    logic xdropped;
    score_t max_score;
    idx_t max_ref_idx;
    idx_t max_query_idx;

    logic [7:0] ref_mem [MEM_DEPTH];
    logic [7:0] query_mem [MEM_DEPTH];
    idx_t ref_addr_q;
    idx_t query_addr_q;

    integer seed;
    int error_count;
    int pass_count;
    int fail_count;
    int done_count;
    logic prev_done;

    `include "align_model.svh"

    xdrop_aligner UUT (
        .clk(clk), .rst(rst), .start(start),
        .complement_ref(complement_ref), .complement_query(complement_query),
        .match(match), .mismatch(mismatch), .n_score(n_score),
        .gap_open(gap_open), .gap_extend(gap_extend), .xdrop(xdrop),
        .ref_len(ref_len), .query_len(query_len),
        .ref_data(ref_data), .query_data(query_data),
        .ref_addr(ref_addr), .query_addr(query_addr),
        .busy(busy), .done(done), .xdropped(xdropped),
        .max_score(max_score), .max_ref_idx(max_ref_idx), .max_query_idx(max_query_idx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous memories with one cycle of read latency
    always @(posedge clk) begin
        ref_addr_q <= ref_addr;
        query_addr_q <= query_addr;
    end

    always @(negedge clk) begin
        ref_data <= ref_mem[ref_addr_q];
        query_data <= query_mem[query_addr_q];
    end

    task automatic log_error(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        error_count++;
    endtask

    // done must be a single-cycle pulse inside a busy run
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(done && prev_done)) else log_error("done high for two cycles");
            assert (!done || busy) else log_error("done while not busy");
            if (done) begin
                done_count = done_count + 1;
            end
        end
        prev_done <= done;
    end

    task automatic set_scoring(input int m, input int mm, input int n, input int go,
                               input int ge, input int xd);
        match = score_t'(m);
        mismatch = score_t'(mm);
        n_score = score_t'(n);
        gap_open = score_t'(go);
        gap_extend = score_t'(ge);
        xdrop = score_t'(xd);
    endtask

    task automatic load_text(input string q, input string r);
        int a;
        for (a = 0; a < q.len(); a++) begin
            query_mem[a] = q[a];
        end
        for (a = 0; a < r.len(); a++) begin
            ref_mem[a] = r[a];
        end
        query_len = idx_t'(q.len());
        ref_len = idx_t'(r.len());
    endtask

    function automatic logic [7:0] random_base();
        int pick;
        pick = $unsigned($random(seed)) % 10;
        case (pick)
            0: return "A";
            1: return "C";
            2: return "G";
            3: return "T";
            4: return "a";
            5: return "c";
            6: return "g";
            7: return "t";
            8: return "N";
            default: return "n";
        endcase
    endfunction

    // reference mostly copies the query so that scores go positive
    task automatic fill_random_pair();
        int qlen;
        int rlen;
        int a;
        qlen = 1 + $unsigned($random(seed)) % NUM_PE;
        rlen = 1 + $unsigned($random(seed)) % 40;
        for (a = 0; a < qlen; a++) begin
            query_mem[a] = random_base();
        end
        for (a = 0; a < rlen; a++) begin
            if (a < qlen && ($unsigned($random(seed)) % 4) != 0) begin
                ref_mem[a] = query_mem[a];
            end else begin
                ref_mem[a] = random_base();
            end
        end
        query_len = idx_t'(qlen);
        ref_len = idx_t'(rlen);
        complement_ref = ($random(seed) & 1) != 0;
        complement_query = ($random(seed) & 1) != 0;
        set_scoring(1 + $unsigned($random(seed)) % 3, -1 - $unsigned($random(seed)) % 4,
                    -($unsigned($random(seed)) % 2), -2 - $unsigned($random(seed)) % 4,
                    -1 - $unsigned($random(seed)) % 2, 300);
    endtask

    task automatic check_results();
        assert (int'(max_score) == exp_score)
            else log_error($sformatf("max_score %0d, expected %0d", max_score, exp_score));
        assert (int'(max_ref_idx) == exp_ref_idx)
            else log_error($sformatf("max_ref_idx %0d, expected %0d", max_ref_idx, exp_ref_idx));
        assert (int'(max_query_idx) == exp_query_idx)
            else log_error($sformatf("max_query_idx %0d, expected %0d",
                                     max_query_idx, exp_query_idx));
        assert (xdropped == exp_xdropped)
            else log_error($sformatf("xdropped %0b, expected %0b", xdropped, exp_xdropped));
    endtask

    task automatic run_alignment();
        int cyc;
        int count_at_start;
        compute_model();
        cyc = 0;
        while (busy && cyc < IDLE_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (busy) begin
            $display("timeout: the DUT did not return to idle before a new start");
            $display("Test failures found");
            $finish;
        end
        count_at_start = done_count;
        start = 1'b1;
        cyc = 0;
        @(negedge clk);
        while (!busy && cyc < START_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!busy) begin
            $display("timeout: the DUT never accepted start");
            $display("Test failures found");
            $finish;
        end
        start = 1'b0;
        cyc = 0;
        while (!done && cyc < RUN_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            $display("timeout: the DUT never signalled done");
            $display("Test failures found");
            $finish;
        end
        check_results();
        @(negedge clk);
        assert (done_count == count_at_start + 1)
            else log_error($sformatf("%0d done pulses in one run", done_count - count_at_start));
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    initial begin
        int errs;
        int cyc;
        int run;
        int runs_before;
        int a;
        seed = 32'hb94d41f4;
        rst = 1'b1;
        start = 1'b0;
        complement_ref = 1'b0;
        complement_query = 1'b0;
        set_scoring(2, -3, -1, -3, -1, 300);
        ref_len = '0;
        query_len = '0;
        ref_data = '0;
        query_data = '0;
        ref_addr_q = '0;
        query_addr_q = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        done_count = 0;
        prev_done = 1'b0;
        for (a = 0; a < MEM_DEPTH; a++) begin
            ref_mem[a] = 8'(a * 37 + 11);
            query_mem[a] = 8'(a * 53 + 5);
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        errs = error_count;
        for (cyc = 0; cyc < 20; cyc++) begin
            @(negedge clk);
            assert (!busy && !done) else log_error("busy or done raised without start");
            assert (ref_addr == 0 && query_addr == 0) else log_error("address moved without start");
        end
        finish_test("reset_idle", errs);

        errs = error_count;
        load_text("ACGTTGCAAGCT", "ACGTTGCAAGCT");
        run_alignment();
        assert (int'(max_score) == 12 * 2) else log_error("identical pair score is not 12 matches");
        assert (max_ref_idx == 12 && max_query_idx == 12 && !xdropped)
            else log_error("identical pair best not at (12,12) or x-dropped");
        finish_test("identical_12", errs);

        errs = error_count;
        for (run = 0; run < 20; run++) begin
            fill_random_pair();
            run_alignment();
        end
        finish_test("random_pairs", errs);

        // matching prefix, then a long run of N
        errs = error_count;
        complement_ref = 1'b0;
        complement_query = 1'b0;
        set_scoring(2, -3, -1, -3, -1, 5);
        load_text("ACGTACGTACGT", "ACGT");
        for (a = 4; a < 40; a++) begin
            ref_mem[a] = "N";
        end
        ref_len = idx_t'(40);
        run_alignment();
        assert (xdropped) else log_error("x-drop did not stop the run");
        finish_test("xdrop_stop", errs);

        errs = error_count;
        set_scoring(2, -3, -1, -3, -1, 300);
        complement_ref = 1'b1;
        load_text("ACGTTGCAAGCT", "TGCAACGTTCGA");
        run_alignment();
        assert (int'(max_score) == 12 * 2 && max_ref_idx == 12 &&
                max_query_idx == 12 && !xdropped)
            else log_error("complemented reference differs from the identical pair");
        complement_ref = 1'b0;
        finish_test("complement", errs);

        errs = error_count;
        runs_before = done_count;
        fill_random_pair();
        run_alignment();
        fill_random_pair();
        run_alignment();
        set_scoring(2, -3, -1, -3, -1, 300);
        complement_ref = 1'b0;
        complement_query = 1'b0;
        load_text("ACGTTGCAAGCT", "ACGTTGCAAGCT");
        run_alignment();
        repeat (3) @(negedge clk);
        assert (done_count == runs_before + 3)
            else log_error($sformatf("%0d done pulses for 3 runs", done_count - runs_before));
        finish_test("back_to_back", errs);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: common/align_cfg_pkg.sv
package align_cfg_pkg;

    // array size and the longest query
    localparam int NUM_PE = 16;
    localparam int PE_IDX_W = $clog2(NUM_PE);

    localparam int SCORE_W = 10;
    localparam int IDX_W = 8;
    localparam int AD_W = 9;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [AD_W-1:0] ad_t;

    // a quarter of the signed range leaves room for one more gap cost
    localparam score_t NEG_INF = score_t'(-(2 ** (SCORE_W - 2)));

    // add that floors at NEG_INF
    function automatic score_t sat_add(score_t a, score_t b);
        logic signed [SCORE_W:0] sum;
        sum = a + b;
        if (sum < NEG_INF) begin
            return NEG_INF;
        end
        return score_t'(sum);
    endfunction

    function automatic score_t max2(score_t a, score_t b);
        return (a > b) ? a : b;
    endfunction

endpackage

// File: common/nt_pkg.sv
package nt_pkg;

    typedef enum logic [2:0] {
        NT_A,
        NT_C,
        NT_G,
        NT_T,
        NT_N
    } nt_t;

    typedef struct packed {
        align_cfg_pkg::score_t match;
        align_cfg_pkg::score_t mismatch;
        align_cfg_pkg::score_t n_score;
        align_cfg_pkg::score_t gap_open;
        align_cfg_pkg::score_t gap_extend;
    } score_param_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_QUERY,
        STREAM,
        DRAIN,
        DONE
    } align_state_t;

    // upper or lower case, anything else is N
    function automatic nt_t ascii_to_nt(logic [7:0] ch, logic complement);
        case (ch)
            8'h41, 8'h61: return complement ? NT_T : NT_A;
            8'h43, 8'h63: return complement ? NT_G : NT_C;
            8'h47, 8'h67: return complement ? NT_C : NT_G;
            8'h54, 8'h74: return complement ? NT_A : NT_T;
            default: return NT_N;
        endcase
    endfunction

endpackage

// File: common/pe_link_if.sv
`timescale 1ns/100ps

interface pe_link_if;
    import align_cfg_pkg::*;
    import nt_pkg::*;

    logic valid;
    nt_t ref_nt;
    idx_t ref_idx;
    score_t h;
    // vertical gap score of the upstream row
    score_t i_gap;
    // previous H of the upstream row, diagonal for the next cell
    score_t h_diag;

    modport src(output valid, ref_nt, ref_idx, h, i_gap, h_diag);
    modport dst(input valid, ref_nt, ref_idx, h, i_gap, h_diag);

endinterface

// File: pe_array/pe.sv
`timescale 1ns/100ps

module pe #(
    parameter int ROW = 0
) (
    input logic clk,
    input logic rst,
    input logic clear,
    input nt_pkg::score_param_t params,
    input logic q_write,
    input nt_pkg::nt_t q_nt,
    pe_link_if.dst up,
    pe_link_if.src down,
    output align_cfg_pkg::score_t h,
    output logic valid
);
    import align_cfg_pkg::*;
    import nt_pkg::*;

    nt_t q_base;
    // horizontal gap of this row
    score_t i_reg;
    score_t s;
    score_t h_boundary;
    score_t i_new;
    score_t d_new;
    score_t h_new;

    // column 0 value of matrix row ROW+1
    assign h_boundary = sat_add(params.gap_open, score_t'(ROW) * params.gap_extend);

    always_comb begin
        if (q_base == NT_N || up.ref_nt == NT_N) begin
            s = params.n_score;
        end else if (q_base == up.ref_nt) begin
            s = params.match;
        end else begin
            s = params.mismatch;
        end
        i_new = max2(sat_add(h, params.gap_open), sat_add(i_reg, params.gap_extend));
        d_new = max2(sat_add(up.h, params.gap_open), sat_add(up.i_gap, params.gap_extend));
        h_new = max2(sat_add(up.h_diag, s), max2(i_new, d_new));
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= 1'b0;
            h <= h_boundary;
            i_reg <= NEG_INF;
        end else begin
            valid <= up.valid;
            if (up.valid) begin
                h <= h_new;
                i_reg <= i_new;
            end
        end
    end

    // values handed to the next row
    always_ff @(posedge clk) begin
        if (up.valid) begin
            down.h_diag <= h;
            down.i_gap <= d_new;
            down.ref_nt <= up.ref_nt;
            down.ref_idx <= up.ref_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (q_write) begin
            q_base <= q_nt;
        end
    end

    assign down.valid = valid;
    assign down.h = h;

endmodule

// File: pe_array/pe_array.sv
`timescale 1ns/100ps

module pe_array (
    input logic clk,
    input logic rst,
    input logic clear,
    input nt_pkg::score_param_t params,
    input logic complement_ref,
    input logic complement_query,
    input logic [7:0] query_data,
    input logic [align_cfg_pkg::PE_IDX_W-1:0] load_slot,
    input logic load_write,
    input logic [7:0] ref_data,
    input align_cfg_pkg::idx_t ref_idx,
    input logic ref_valid,
    input align_cfg_pkg::idx_t query_len,
    output align_cfg_pkg::score_t h_col [align_cfg_pkg::NUM_PE],
    output logic [align_cfg_pkg::NUM_PE-1:0] cell_valid,
    output align_cfg_pkg::idx_t ref_idx_col [align_cfg_pkg::NUM_PE],
    output logic array_empty
);
    import align_cfg_pkg::*;
    import nt_pkg::*;

    nt_t q_nt;
    score_t row0_prev;
    score_t row0_h;
    logic row0_first;
    logic [NUM_PE-1:0] pe_valid;

    // link k feeds PE k, the last one carries the bottom row out
    pe_link_if link [NUM_PE+1] ();

    assign q_nt = ascii_to_nt(query_data, complement_query);

    // row 0 boundary, H(0,0) is zero
    assign row0_h = row0_first ? params.gap_open : sat_add(row0_prev, params.gap_extend);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            row0_prev <= '0;
            row0_first <= 1'b1;
        end else if (ref_valid) begin
            row0_prev <= row0_h;
            row0_first <= 1'b0;
        end
    end

    assign link[0].valid = ref_valid;
    assign link[0].ref_nt = ascii_to_nt(ref_data, complement_ref);
    assign link[0].ref_idx = ref_idx;
    assign link[0].h = row0_h;
    assign link[0].h_diag = row0_prev;
    assign link[0].i_gap = NEG_INF;

    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        pe #(
            .ROW(k)
        ) u_pe (
            .clk(clk),
            .rst(rst),
            .clear(clear),
            .params(params),
            .q_write(load_write && (load_slot == k)),
            .q_nt(q_nt),
            .up(link[k]),
            .down(link[k+1]),
            .h(h_col[k]),
            .valid(pe_valid[k])
        );

        // rows past the query hold no matrix cells
        assign cell_valid[k] = pe_valid[k] && (k < query_len);
        assign ref_idx_col[k] = link[k+1].ref_idx;
    end

    assign array_empty = ~|cell_valid;

endmodule

// File: sources.f
+incdir+bench
common/align_cfg_pkg.sv
common/nt_pkg.sv
common/pe_link_if.sv
verilog/align_fsm.sv
verilog/stream_counter.sv
pe_array/pe.sv
pe_array/pe_array.sv
verilog/max_tracker.sv
verilog/xdrop_aligner.sv
bench/tb_xdrop_aligner.sv

// File: verilog/align_fsm.sv
`timescale 1ns/100ps

module align_fsm (
    input logic clk,
    input logic rst,
    input logic start,
    input logic query_loaded,
    input logic ref_done,
    input logic array_empty,
    input logic xdrop_hit,
    output logic clear,
    output logic load_en,
    output logic stream_en,
    output logic busy,
    output logic done
);
    import nt_pkg::*;

    align_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= LOAD_QUERY;
                    end
                end
                LOAD_QUERY: begin
                    if (query_loaded) begin
                        state <= STREAM;
                    end
                end
                STREAM: begin
                    // x-drop ends the run at once, cells in flight are dropped
                    if (xdrop_hit) begin
                        state <= DONE;
                    end else if (ref_done) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (array_empty) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign clear = (state == IDLE) && start;
    assign load_en = (state == LOAD_QUERY);
    assign stream_en = (state == STREAM);
    assign busy = (state != IDLE);
    assign done = (state == DONE);

endmodule

// File: verilog/max_tracker.sv
`timescale 1ns/100ps

module max_tracker (
    input logic clk,
    input logic rst,
    input logic clear,
    input align_cfg_pkg::score_t xdrop,
    input align_cfg_pkg::score_t h_col [align_cfg_pkg::NUM_PE],
    input logic [align_cfg_pkg::NUM_PE-1:0] cell_valid,
    input align_cfg_pkg::idx_t ref_idx_col [align_cfg_pkg::NUM_PE],
    output logic xdrop_hit,
    output align_cfg_pkg::score_t max_score,
    output align_cfg_pkg::idx_t max_ref_idx,
    output align_cfg_pkg::idx_t max_query_idx
);
    import align_cfg_pkg::*;

    // heap with the root at 1 and the leaves from NUM_PE up
    score_t node_score [1:2*NUM_PE-1];
    logic node_valid [1:2*NUM_PE-1];
    logic [PE_IDX_W-1:0] node_pe [1:2*NUM_PE-1];

    score_t ad_score;
    idx_t ad_ref;
    idx_t ad_query;
    logic ad_valid;
    logic signed [SCORE_W:0] floor_score;

    always_comb begin
        for (int n = 0; n < NUM_PE; n++) begin
            node_score[NUM_PE+n] = h_col[n];
            node_valid[NUM_PE+n] = cell_valid[n];
            node_pe[NUM_PE+n] = PE_IDX_W'(n);
        end
        // left child is the lower PE and wins a tie
        for (int n = NUM_PE - 1; n > 0; n--) begin
            if (node_valid[2*n+1] &&
                (!node_valid[2*n] || node_score[2*n+1] > node_score[2*n])) begin
                node_score[n] = node_score[2*n+1];
                node_valid[n] = 1'b1;
                node_pe[n] = node_pe[2*n+1];
            end else begin
                node_score[n] = node_score[2*n];
                node_valid[n] = node_valid[2*n];
                node_pe[n] = node_pe[2*n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            ad_valid <= 1'b0;
        end else begin
            ad_valid <= node_valid[1];
        end
    end

    always_ff @(posedge clk) begin
        ad_score <= node_score[1];
        ad_ref <= ref_idx_col[node_pe[1]];
        ad_query <= idx_t'(node_pe[1]) + 1'b1;
    end

    assign floor_score = max_score - xdrop;

    // frozen once the x-drop fires
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            xdrop_hit <= 1'b0;
            max_score <= '0;
            max_ref_idx <= '0;
            max_query_idx <= '0;
        end else if (ad_valid && !xdrop_hit) begin
            if (ad_score >= max_score) begin
                max_score <= ad_score;
                max_ref_idx <= ad_ref;
                max_query_idx <= ad_query;
            end else if (ad_score < floor_score) begin
                xdrop_hit <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/stream_counter.sv
`timescale 1ns/100ps

module stream_counter (
    input logic clk,
    input logic rst,
    input logic clear,
    input logic load_en,
    input logic stream_en,
    input align_cfg_pkg::idx_t ref_len,
    input align_cfg_pkg::idx_t query_len,
    output align_cfg_pkg::idx_t query_addr,
    output align_cfg_pkg::idx_t ref_addr,
    output logic [align_cfg_pkg::PE_IDX_W-1:0] load_slot,
    output logic load_write,
    output align_cfg_pkg::idx_t ref_idx,
    output logic ref_valid,
    output logic query_loaded,
    output logic ref_done
);
    import align_cfg_pkg::*;

    logic q_more;
    logic r_more;

    assign q_more = query_addr < query_len;
    assign r_more = ref_addr < ref_len;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            query_addr <= '0;
            ref_addr <= '0;
            load_write <= 1'b0;
            ref_valid <= 1'b0;
        end else begin
            // data shows up one cycle after its address
            load_write <= load_en && q_more;
            ref_valid <= stream_en && r_more;
            if (load_en && q_more) begin
                query_addr <= query_addr + 1'b1;
            end
            if (stream_en && r_more) begin
                ref_addr <= ref_addr + 1'b1;
            end
        end
    end

    // slot and index line up with the read data
    always_ff @(posedge clk) begin
        load_slot <= query_addr[PE_IDX_W-1:0];
        ref_idx <= ref_addr + 1'b1;
    end

    assign query_loaded = !q_more;
    assign ref_done = !r_more;

endmodule

// File: verilog/xdrop_aligner.sv
`timescale 1ns/100ps

module xdrop_aligner (
    input logic clk,
    input logic rst,
    input logic start,
    input logic complement_ref,
    input logic complement_query,
    input align_cfg_pkg::score_t match,
    input align_cfg_pkg::score_t mismatch,
    input align_cfg_pkg::score_t n_score,
    input align_cfg_pkg::score_t gap_open,
    input align_cfg_pkg::score_t gap_extend,
    input align_cfg_pkg::score_t xdrop,
    input align_cfg_pkg::idx_t ref_len,
    input align_cfg_pkg::idx_t query_len,
    input logic [7:0] ref_data,
    input logic [7:0] query_data,
    output align_cfg_pkg::idx_t ref_addr,
    output align_cfg_pkg::idx_t query_addr,
    output logic busy,
    output logic done,
    output logic xdropped,
    output align_cfg_pkg::score_t max_score,
    output align_cfg_pkg::idx_t max_ref_idx,
    output align_cfg_pkg::idx_t max_query_idx
);
    import align_cfg_pkg::*;
    import nt_pkg::*;

    score_param_t params;
    logic clear;
    logic load_en;
    logic stream_en;
    logic query_loaded;
    logic ref_done;
    logic array_empty;
    logic xdrop_hit;
    logic [PE_IDX_W-1:0] load_slot;
    logic load_write;
    idx_t ref_idx;
    logic ref_valid;
    score_t h_col [NUM_PE];
    logic [NUM_PE-1:0] cell_valid;
    idx_t ref_idx_col [NUM_PE];

    assign params = '{match, mismatch, n_score, gap_open, gap_extend};
    assign xdropped = xdrop_hit;

    align_fsm u_fsm (
        .clk(clk), .rst(rst), .start(start),
        .query_loaded(query_loaded), .ref_done(ref_done),
        .array_empty(array_empty), .xdrop_hit(xdrop_hit),
        .clear(clear), .load_en(load_en), .stream_en(stream_en),
        .busy(busy), .done(done)
    );

    stream_counter u_cnt (
        .clk(clk), .rst(rst), .clear(clear),
        .load_en(load_en), .stream_en(stream_en),
        .ref_len(ref_len), .query_len(query_len),
        .query_addr(query_addr), .ref_addr(ref_addr),
        .load_slot(load_slot), .load_write(load_write),
        .ref_idx(ref_idx), .ref_valid(ref_valid),
        .query_loaded(query_loaded), .ref_done(ref_done)
    );

    pe_array u_array (
        .clk(clk), .rst(rst), .clear(clear), .params(params),
        .complement_ref(complement_ref), .complement_query(complement_query),
        .query_data(query_data), .load_slot(load_slot), .load_write(load_write),
        .ref_data(ref_data), .ref_idx(ref_idx), .ref_valid(ref_valid),
        .query_len(query_len), .h_col(h_col), .cell_valid(cell_valid),
        .ref_idx_col(ref_idx_col), .array_empty(array_empty)
    );

    max_tracker u_max (
        .clk(clk), .rst(rst), .clear(clear), .xdrop(xdrop),
        .h_col(h_col), .cell_valid(cell_valid), .ref_idx_col(ref_idx_col),
        .xdrop_hit(xdrop_hit), .max_score(max_score),
        .max_ref_idx(max_ref_idx), .max_query_idx(max_query_idx)
    );

endmodule
